// ==== Makefile ====
# Verilator flow for the matrix-multiply offload
# run from the project root, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mm_top
RTL_TOP   ?= mm_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
LINTFLAGS ?= -Wall
RTL_SRCS  ?= hdl/mm_pkg.sv hdl/operand_buffer.sv hdl/dma_engine.sv \
             hdl/mm_engine.sv hdl/mm_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) +incdir+hdl --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+hdl
hdl/mm_pkg.sv
hdl/operand_buffer.sv
hdl/dma_engine.sv
hdl/mm_engine.sv
hdl/mm_top.sv
sim/mm_checker.sv
sim/tb_mm_top.sv

// ==== hdl/dma_engine.sv ====
// ================================================
// fetch A columns and B rows per step, push operand pairs
// under credit, then write C back as one 16-beat burst
// ================================================
`timescale 1ns/1ps
`include "mm_consts.svh"

module dma_engine import mm_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start_i,
    input  logic [31:0]   mat_a_addr_i,
    input  logic [31:0]   mat_b_addr_i,
    input  logic [31:0]   mat_c_addr_i,
    input  logic [7:0]    mat_width_i,
    output logic          done_o,
    output mem_ar_t       ar_o,
    input  logic          ar_ready_i,
    input  mem_r_t        r_i,
    output logic          r_ready_o,
    output mem_aw_t       aw_o,
    input  logic          aw_ready_i,
    output mem_w_t        w_o,
    input  logic          w_ready_i,
    input  logic          b_valid_i,
    output logic          b_ready_o,
    output logic          opnd_push_o,
    output operand_pair_t opnd_data_o,
    input  logic          opnd_credit_i,
    input  logic          res_valid_i,
    input  c_row_t        res_data_i,
    output logic          res_pop_o
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_A,
        ST_RD_B,
        ST_GATHER,
        ST_WR_ADDR,
        ST_WR_DATA,
        ST_WR_RESP
    } state_t;

    localparam int          CRED_W     = $clog2(`MM_BUF_DEPTH + 1);
    // bytes per burst, stride between columns of A or rows of B
    localparam logic [31:0] STEP_BYTES = `MM_BURST_BEATS * (`MM_DW / 8);

    // control
    state_t            state_q;
    logic [7:0]        step_q;
    logic [CRED_W-1:0] credits_q;
    logic              push_q;
    logic [3:0]        beat_q;
    // job registers and gathered operands
    logic [31:0]       a_base_q;
    logic [31:0]       b_base_q;
    logic [31:0]       c_base_q;
    logic [7:0]        width_q;
    vec_t              a_vec_q;
    vec_t              b_vec_q;
    logic              pair_last_q;

    logic              r_hs;
    logic              pair_done;
    logic              w_hs;
    logic              has_credit;
    logic              last_step;
    logic [31:0]       step_offset;

    assign r_hs        = r_i.valid && r_ready_o;
    // B answers after A, so its last beat closes the pair
    assign pair_done   = r_hs && r_i.id && r_i.last;
    assign w_hs        = (state_q == ST_WR_DATA) && res_valid_i && w_ready_i;
    // a push still in flight has already spent its credit
    assign has_credit  = credits_q > CRED_W'(push_q);
    assign last_step   = (step_q == width_q - 8'd1);
    assign step_offset = 32'(step_q) * STEP_BYTES;

    assign done_o                = (state_q == ST_IDLE);
    assign opnd_push_o           = push_q;
    assign opnd_data_o.a_col     = a_vec_q;
    assign opnd_data_o.b_row     = b_vec_q;
    assign opnd_data_o.last      = pair_last_q;

    // memory port drive, all from state
    always_comb begin
        ar_o      = '0;
        aw_o      = '0;
        w_o       = '0;
        r_ready_o = 1'b0;
        b_ready_o = 1'b0;
        res_pop_o = 1'b0;
        case (state_q)
            ST_RD_A: begin
                ar_o.valid = has_credit;
                ar_o.addr  = a_base_q + step_offset;
                ar_o.id    = 1'b0;
            end
            ST_RD_B: begin
                ar_o.valid = 1'b1;
                ar_o.addr  = b_base_q + step_offset;
                ar_o.id    = 1'b1;
                // A beats may already be returning
                r_ready_o  = 1'b1;
            end
            ST_GATHER: begin
                r_ready_o = 1'b1;
            end
            ST_WR_ADDR: begin
                aw_o.valid = 1'b1;
                aw_o.addr  = c_base_q;
            end
            ST_WR_DATA: begin
                // head row stays put until its 4th beat leaves
                w_o.valid = res_valid_i;
                w_o.data  = res_data_i.row[beat_q[1:0]];
                w_o.last  = (beat_q == 4'd15);
                res_pop_o = w_hs && (beat_q[1:0] == 2'd3);
            end
            ST_WR_RESP: begin
                b_ready_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            step_q    <= '0;
            credits_q <= CRED_W'(`MM_BUF_DEPTH);
            push_q    <= 1'b0;
            beat_q    <= '0;
        end else begin
            push_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_RD_A;
                        step_q  <= '0;
                        beat_q  <= '0;
                    end
                end
                ST_RD_A: begin
                    if (ar_o.valid && ar_ready_i) begin
                        state_q <= ST_RD_B;
                    end
                end
                ST_RD_B: begin
                    if (ar_ready_i) begin
                        state_q <= ST_GATHER;
                    end
                end
                ST_GATHER: begin
                    if (pair_done) begin
                        push_q  <= 1'b1;
                        step_q  <= step_q + 8'd1;
                        state_q <= last_step ? ST_WR_ADDR : ST_RD_A;
                    end
                end
                ST_WR_ADDR: begin
                    if (aw_ready_i) begin
                        state_q <= ST_WR_DATA;
                    end
                end
                ST_WR_DATA: begin
                    if (w_hs) begin
                        beat_q <= beat_q + 4'd1;
                        if (res_pop_o && res_data_i.last) begin
                            state_q <= ST_WR_RESP;
                        end
                    end
                end
                ST_WR_RESP: begin
                    if (b_valid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
            // operand link credits
            case ({opnd_credit_i, push_q})
                2'b10:   credits_q <= credits_q + 1'b1;
                2'b01:   credits_q <= credits_q - 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // job registers latched at start
        if (state_q == ST_IDLE && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
            width_q  <= mat_width_i;
        end
        // beat j lands in element j after four shifts
        if (r_hs) begin
            if (r_i.id) begin
                b_vec_q <= {r_i.data, b_vec_q[`MM_SA_WIDTH-1:1]};
            end else begin
                a_vec_q <= {r_i.data, a_vec_q[`MM_SA_WIDTH-1:1]};
            end
        end
        if (pair_done) begin
            pair_last_q <= last_step;
        end
    end

endmodule

// ==== hdl/mm_consts.svh ====
// ================================================
// sizing constants for the matrix-multiply offload
// include wherever array, element or buffer sizes are needed
// ================================================
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// side of the mac array, C is MM_SA_WIDTH x MM_SA_WIDTH
`define MM_SA_WIDTH 4

// element width in bits
`define MM_DW 32

// entries per credit buffer, also the sender's starting credits
`define MM_BUF_DEPTH 4

// beats per read burst, one column of A or one row of B
`define MM_BURST_BEATS `MM_SA_WIDTH

`endif

// ==== hdl/mm_engine.sv ====
// ================================================
// parallel mac array; sums outer products of operand pairs
// and emits C row by row to the result buffer under credit
// ================================================
`timescale 1ns/1ps
`include "mm_consts.svh"

module mm_engine import mm_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          opnd_valid_i,
    input  operand_pair_t opnd_data_i,
    output logic          opnd_pop_o,
    output logic          res_push_o,
    output c_row_t        res_data_o,
    input  logic          res_credit_i
);
    localparam int N      = `MM_SA_WIDTH;
    localparam int ROW_W  = $clog2(N);
    localparam int CRED_W = $clog2(`MM_BUF_DEPTH + 1);

    // accumulators, acc_q[i][j] is C[i][j]
    vec_t              acc_q [N];
    vec_t              prod  [N];
    // popped pair, added one cycle after the pop
    operand_pair_t     pair_q;
    logic              pair_v_q;
    // emit phase and pending clear
    logic              emit_q;
    logic              clear_q;
    logic [ROW_W-1:0]  row_q;
    logic [CRED_W-1:0] credits_q;

    // stop popping once the last pair is taken
    assign opnd_pop_o      = opnd_valid_i && !emit_q && !(pair_v_q && pair_q.last);
    assign res_push_o      = emit_q && (credits_q != '0);
    assign res_data_o.row  = acc_q[row_q];
    assign res_data_o.last = (row_q == ROW_W'(N - 1));

    // outer product, low 32 bits so sums wrap
    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                prod[i][j] = pair_q.a_col[i] * pair_q.b_row[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_v_q  <= 1'b0;
            emit_q    <= 1'b0;
            clear_q   <= 1'b1;
            row_q     <= '0;
            credits_q <= CRED_W'(`MM_BUF_DEPTH);
        end else begin
            pair_v_q <= opnd_pop_o;
            if (pair_v_q) begin
                clear_q <= 1'b0;
                if (pair_q.last) begin
                    emit_q <= 1'b1;
                end
            end
            if (res_push_o) begin
                row_q <= row_q + 1'b1;
                // back to accumulate, next pair starts fresh
                if (res_data_o.last) begin
                    emit_q  <= 1'b0;
                    clear_q <= 1'b1;
                    row_q   <= '0;
                end
            end
            // result link credits
            case ({res_credit_i, res_push_o})
                2'b10:   credits_q <= credits_q + 1'b1;
                2'b01:   credits_q <= credits_q - 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (opnd_pop_o) begin
            pair_q <= opnd_data_i;
        end
        if (pair_v_q) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    // first pair of a job overwrites
                    acc_q[i][j] <= clear_q ? prod[i][j] : acc_q[i][j] + prod[i][j];
                end
            end
        end
    end

endmodule

// ==== hdl/mm_pkg.sv ====
// ================================================
// shared struct types for the memory port, the operand
// link and the result link; import with mm_pkg::*
// ================================================
`include "mm_consts.svh"

package mm_pkg;

    // read request, id 0 fetches A and id 1 fetches B
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        id;
    } mem_ar_t;

    // read data beat
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        id;
        logic        last;
    } mem_r_t;

    // write request, fixed 16-beat burst
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_aw_t;

    // write data beat
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } mem_w_t;

    // one row or column, element 0 in the low bits
    typedef logic [`MM_SA_WIDTH-1:0][`MM_DW-1:0] vec_t;

    // column k of A with row k of B, last marks step K-1
    typedef struct packed {
        vec_t a_col;
        vec_t b_row;
        logic last;
    } operand_pair_t;

    // one row of C, last marks the final row
    typedef struct packed {
        vec_t row;
        logic last;
    } c_row_t;

endpackage

// ==== hdl/mm_top.sv ====
// ================================================
// offload top: dma engine, operand buffer, mac engine,
// result buffer; the memory port goes straight out
// ================================================
`timescale 1ns/1ps
`include "mm_consts.svh"

module mm_top import mm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  logic [31:0] mat_a_addr_i,
    input  logic [31:0] mat_b_addr_i,
    input  logic [31:0] mat_c_addr_i,
    input  logic [7:0]  mat_width_i,
    output logic        done_o,
    output mem_ar_t     ar_o,
    input  logic        ar_ready_i,
    input  mem_r_t      r_i,
    output logic        r_ready_o,
    output mem_aw_t     aw_o,
    input  logic        aw_ready_i,
    output mem_w_t      w_o,
    input  logic        w_ready_i,
    input  logic        b_valid_i,
    output logic        b_ready_o
);
    // operand link, dma to mac
    logic          opnd_push;
    operand_pair_t opnd_push_data;
    logic          opnd_credit;
    logic          opnd_valid;
    operand_pair_t opnd_head;
    logic          opnd_pop;
    // result link, mac to dma
    logic          res_push;
    c_row_t        res_push_data;
    logic          res_credit;
    logic          res_valid;
    c_row_t        res_head;
    logic          res_pop;

    dma_engine u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .mat_a_addr_i  (mat_a_addr_i),
        .mat_b_addr_i  (mat_b_addr_i),
        .mat_c_addr_i  (mat_c_addr_i),
        .mat_width_i   (mat_width_i),
        .done_o        (done_o),
        .ar_o          (ar_o),
        .ar_ready_i    (ar_ready_i),
        .r_i           (r_i),
        .r_ready_o     (r_ready_o),
        .aw_o          (aw_o),
        .aw_ready_i    (aw_ready_i),
        .w_o           (w_o),
        .w_ready_i     (w_ready_i),
        .b_valid_i     (b_valid_i),
        .b_ready_o     (b_ready_o),
        .opnd_push_o   (opnd_push),
        .opnd_data_o   (opnd_push_data),
        .opnd_credit_i (opnd_credit),
        .res_valid_i   (res_valid),
        .res_data_i    (res_head),
        .res_pop_o     (res_pop)
    );

    operand_buffer #(
        .payload_t (operand_pair_t),
        .DEPTH     (`MM_BUF_DEPTH)
    ) u_opnd_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (opnd_push),
        .push_data_i (opnd_push_data),
        .pop_i       (opnd_pop),
        .credit_o    (opnd_credit),
        .valid_o     (opnd_valid),
        .pop_data_o  (opnd_head)
    );

    mm_engine u_mm (
        .clk          (clk),
        .rst_n        (rst_n),
        .opnd_valid_i (opnd_valid),
        .opnd_data_i  (opnd_head),
        .opnd_pop_o   (opnd_pop),
        .res_push_o   (res_push),
        .res_data_o   (res_push_data),
        .res_credit_i (res_credit)
    );

    operand_buffer #(
        .payload_t (c_row_t),
        .DEPTH     (`MM_BUF_DEPTH)
    ) u_res_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (res_push),
        .push_data_i (res_push_data),
        .pop_i       (res_pop),
        .credit_o    (res_credit),
        .valid_o     (res_valid),
        .pop_data_o  (res_head)
    );

endmodule

// ==== hdl/operand_buffer.sv ====
// ================================================
// credit-returning FIFO, payload set by type parameter
// sender starts with DEPTH credits; each pop returns one
// ================================================
`timescale 1ns/1ps
`include "mm_consts.svh"

module operand_buffer #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `MM_BUF_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     credit_o,
    output logic     valid_o,
    output payload_t pop_data_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage
    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop_ok;

    // wrap at DEPTH, no power-of-two requirement
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // head entry always visible
    assign valid_o    = (count_q != '0);
    assign pop_data_o = mem_q[rd_ptr_q];
    // ignore pops of an empty buffer
    assign pop_ok     = pop_i && valid_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            // one credit back per pop, a cycle later
            credit_o <= pop_ok;
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // sender holds credits, so a push never meets a full buffer
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

// ==== sim/mm_checker.sv ====
// ================================================
// watches the write port and done_o of the offload,
// compares every C beat with the expected matrix
// and prints one line per finished test
// ================================================
`timescale 1ns/1ps

module mm_checker import mm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic              done_i,
    input  mem_aw_t           aw_i,
    input  logic              aw_ready_i,
    input  mem_w_t            w_i,
    input  logic              w_ready_i,
    input  logic              b_valid_i,
    input  logic              b_ready_i,
    input  logic [127:0]      name_i,
    input  logic [31:0]       c_addr_i,
    input  logic [15:0][31:0] exp_c_i,
    output int                tests_o,
    output int                failed_o,
    output int                errors_o
);
    // job latched when start_i is taken
    logic [127:0]      name_q   = "reset";
    logic [31:0]       c_addr_q = '0;
    logic [15:0][31:0] exp_q    = '0;
    logic              busy_q   = 1'b0;
    logic              start_q  = 1'b0;
    logic              done_q   = 1'b1;
    logic              rst_q    = 1'b0;
    // totals
    int                n_tests  = 0;
    int                n_failed = 0;
    int                n_errors = 0;
    // per-test counts
    int                test_err = 0;
    int                aw_cnt   = 0;
    int                w_cnt    = 0;
    int                last_cnt = 0;
    int                b_cnt    = 0;

    assign tests_o  = n_tests;
    assign failed_o = n_failed;
    assign errors_o = n_errors;

    task automatic flag(input string msg);
        n_errors++;
        test_err++;
        $display("%0s: %0s", name_q, msg);
    endtask

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_errors++;
        test_err++;
        $display("[FAIL] %0s %0s expected %08h actual %08h", name_q, what, exp, act);
    endtask

    task automatic open_test();
        name_q   = name_i;
        c_addr_q = c_addr_i;
        exp_q    = exp_c_i;
        test_err = 0;
        aw_cnt   = 0;
        w_cnt    = 0;
        last_cnt = 0;
        b_cnt    = 0;
        busy_q   = 1'b1;
    endtask

    task automatic close_test();
        // burst shape, one AW and 16 beats with a single last
        if (aw_cnt != 1) flag($sformatf("%0d write requests instead of 1", aw_cnt));
        if (w_cnt != 16) flag($sformatf("%0d write beats instead of 16", w_cnt));
        if (last_cnt != 1) flag($sformatf("%0d beats flagged last instead of 1", last_cnt));
        if (b_cnt != 1) flag("done_o rose without exactly one write response");
        n_tests++;
        if (test_err != 0) begin
            n_failed++;
            $display("test %0s: %0d errors", name_q, test_err);
        end else begin
            $display("test %0s: ok", name_q);
        end
        busy_q = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!rst_q && !done_i) flag("done_o is low right after reset");
            if (start_q && done_i) flag("done_o did not drop after start_i");
            // finish before start, both can land on one edge
            if (busy_q && done_i && !done_q) close_test();
            if (start_i && done_i) open_test();
            if (busy_q) begin
                if (aw_i.valid && aw_ready_i) begin
                    aw_cnt++;
                    if (aw_i.addr !== c_addr_q) mismatch("write address", c_addr_q, aw_i.addr);
                end
                if (w_i.valid && w_ready_i) begin
                    if (aw_cnt == 0) flag("write beat before the write request");
                    // beat i carries C[i/4][i%4]
                    if (w_cnt < 16 && w_i.data !== exp_q[w_cnt]) begin
                        mismatch($sformatf("C[%0d][%0d]", w_cnt / 4, w_cnt % 4),
                                 exp_q[w_cnt], w_i.data);
                    end
                    if (w_i.last) begin
                        last_cnt++;
                        if (w_cnt != 15) flag($sformatf("last flag on beat %0d", w_cnt));
                    end
                    w_cnt++;
                end
                if (b_valid_i && b_ready_i) b_cnt++;
            end
            start_q = start_i && done_i;
        end
        rst_q  = rst_n;
        done_q = done_i;
    end

endmodule

// ==== sim/mm_stimulus.txt ====
# matrix-multiply tests, all numbers hex
# test <name> <K> <a_addr> <b_addr> <c_addr>
# step <a_col 0..3> <b_row 0..3>, one line per k; c <expected C row>, rows 0..3
test identity 4 00000000 00000100 00000200
step 1 0 0 0 1 2 3 4
step 0 1 0 0 5 6 7 8
step 0 0 1 0 9 a b c
step 0 0 0 1 d e f 10
c 1 2 3 4
c 5 6 7 8
c 9 a b c
c d e f 10
test outer_k1 1 00000300 00000340 00000380
step 1 2 3 4 5 6 7 8
c 5 6 7 8
c a c e 10
c f 12 15 18
c 14 18 1c 20
test accum_k8 8 00000400 00000500 00000600
step 1 0 2 1 0 1 3 1
step 1 1 2 1 1 1 3 2
step 1 2 2 1 2 1 3 3
step 1 3 2 1 3 1 3 4
step 1 4 2 1 4 1 3 5
step 1 5 2 1 5 1 3 6
step 1 6 2 1 6 1 3 7
step 1 7 2 1 7 1 3 8
c 1c 8 18 24
c 8c 1c 54 a8
c 38 10 30 48
c 1c 8 18 24
test wrap_k2 2 00000700 00000740 00000780
step ffffffff 2 80000000 10000 3 fffffffe 2 10000
step 1 ffffffff 0 1 5 7 80000000 ffffffff
c 2 9 7ffffffe fffeffff
c 1 fffffff5 80000004 20001
c 80000000 0 0 0
c 30005 fffe0007 80020000 ffffffff
test mixed_k3 3 00000800 00000840 00000200
step 1 2 3 4 1 0 0 0
step 0 1 0 1 0 2 0 0
step 2 2 2 2 1 1 1 1
c 3 2 2 2
c 4 4 2 2
c 5 2 2 2
c 6 4 2 2

// ==== sim/tb_mm_top.sv ====
// ================================================
// testbench for the matrix-multiply offload: clock, reset,
// memory model with random stalls, tests from the stimulus file
// ================================================
`timescale 1ns/1ps

module tb_mm_top import mm_pkg::*; ();
    localparam int MAX_TESTS = 16;
    localparam int MEM_WORDS = 4096;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    logic [31:0]       a_addr;
    logic [31:0]       b_addr;
    logic [31:0]       c_addr;
    logic [7:0]        width;
    logic              done;
    mem_ar_t           ar;
    mem_aw_t           aw;
    mem_w_t            w;
    logic              r_ready;
    logic              b_ready;
    // memory side, driven on the falling edge
    logic              ar_ready = 1'b0;
    mem_r_t            r        = '0;
    logic              aw_ready = 1'b0;
    logic              w_ready  = 1'b0;
    logic              b_valid  = 1'b0;

    // tests read from the file
    logic [127:0]      test_name [MAX_TESTS];
    logic [7:0]        test_k    [MAX_TESTS];
    logic [31:0]       test_a    [MAX_TESTS];
    logic [31:0]       test_b    [MAX_TESTS];
    logic [31:0]       test_c    [MAX_TESTS];
    logic [15:0][31:0] test_exp  [MAX_TESTS];
    int                n_tests;
    int                cycle_limit;
    int                cycles = 0;
    // running test, seen by the checker
    logic [127:0]      cur_name;
    logic [31:0]       cur_c;
    logic [15:0][31:0] cur_exp;
    int                tests_done;
    int                tests_failed;
    int                errors;

    // memory model state
    logic [31:0]       mem [MEM_WORDS];
    logic [31:0]       rq_addr [$];
    logic              rq_id   [$];
    int                r_beat  = 0;
    logic              r_taken = 1'b0;
    logic [11:0]       wr_word = '0;
    int                b_delay = 0;
    logic              b_taken = 1'b0;
    logic [31:0]       rnd     = 32'h576;

    mm_top i_mm_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .mat_a_addr_i (a_addr),
        .mat_b_addr_i (b_addr),
        .mat_c_addr_i (c_addr),
        .mat_width_i  (width),
        .done_o       (done),
        .ar_o         (ar),
        .ar_ready_i   (ar_ready),
        .r_i          (r),
        .r_ready_o    (r_ready),
        .aw_o         (aw),
        .aw_ready_i   (aw_ready),
        .w_o          (w),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_ready_o    (b_ready)
    );

    mm_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start),
        .done_i     (done),
        .aw_i       (aw),
        .aw_ready_i (aw_ready),
        .w_i        (w),
        .w_ready_i  (w_ready),
        .b_valid_i  (b_valid),
        .b_ready_i  (b_ready),
        .name_i     (cur_name),
        .c_addr_i   (cur_c),
        .exp_c_i    (cur_exp),
        .tests_o    (tests_done),
        .failed_o   (tests_failed),
        .errors_o   (errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fills memory with A columns and B rows, keeps expected C
    task automatic load_stimulus();
        int          fd;
        int          t;
        int          step;
        int          row;
        int          j;
        string       line;
        logic [63:0] tag;
        logic [31:0] v [8];
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hbad0_0000 | i;
        end
        // reset cycles and wrap-up
        cycle_limit = 10;
        n_tests = 0;
        fd = $fopen("sim/mm_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/mm_stimulus.txt, no tests to run");
            return;
        end
        t = -1;
        step = 0;
        row = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s", tag));
            if (tag == "test" && t < MAX_TESTS - 1) begin
                t++;
                void'($sscanf(line, "%s %s %h %h %h %h", tag, test_name[t], test_k[t],
                              test_a[t], test_b[t], test_c[t]));
                step = 0;
                row = 0;
                cycle_limit += 200 + 60 * test_k[t];
            end else if (tag == "step" && t >= 0) begin
                void'($sscanf(line, "%s %h %h %h %h %h %h %h %h", tag,
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
                // step k sits at base + k*16
                for (j = 0; j < 4; j++) begin
                    mem[test_a[t][13:2] + step * 4 + j] = v[j];
                    mem[test_b[t][13:2] + step * 4 + j] = v[j + 4];
                end
                step++;
            end else if (tag == "c" && t >= 0) begin
                void'($sscanf(line, "%s %h %h %h %h", tag, v[0], v[1], v[2], v[3]));
                for (j = 0; j < 4; j++) begin
                    test_exp[t][row * 4 + j] = v[j];
                end
                row++;
            end
        end
        $fclose(fd);
        n_tests = t + 1;
    endtask

    // one start pulse, then wait for done_o to come back
    task automatic run_test(input int t);
        cur_name = test_name[t];
        cur_c    = test_c[t];
        cur_exp  = test_exp[t];
        a_addr   = test_a[t];
        b_addr   = test_b[t];
        c_addr   = test_c[t];
        width    = test_k[t];
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);
    endtask

    initial begin
        forever #2 clk = ~clk;
    end

    // handshakes complete at the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (ar.valid && ar_ready) begin
                rq_addr.push_back(ar.addr);
                rq_id.push_back(ar.id);
            end
            if (r.valid && r_ready) begin
                r_taken = 1'b1;
                r_beat++;
                if (r_beat == 4) begin
                    r_beat = 0;
                    void'(rq_addr.pop_front());
                    void'(rq_id.pop_front());
                end
            end
            if (aw.valid && aw_ready) wr_word = aw.addr[13:2];
            if (w.valid && w_ready) begin
                mem[wr_word] = w.data;
                wr_word++;
                if (w.last) b_delay = 2;
            end
            if (b_valid && b_ready) b_taken = 1'b1;
        end
    end

    // memory responses with random stalls
    always @(negedge clk) begin
        rnd = xorshift(rnd);
        ar_ready = rnd[0] | rnd[1];
        aw_ready = rnd[2] | rnd[3];
        w_ready  = rnd[4] | rnd[5];
        // a beat on offer stays until taken
        if (!r.valid || r_taken) begin
            r = '0;
            if (rq_addr.size() != 0 && (rnd[6] | rnd[7])) begin
                r.valid = 1'b1;
                r.data  = mem[rq_addr[0][13:2] + r_beat];
                r.id    = rq_id[0];
                r.last  = (r_beat == 3);
            end
        end
        r_taken = 1'b0;
        if (b_taken) begin
            b_valid = 1'b0;
            b_taken = 1'b0;
        end
        // B two cycles after the last W beat
        if (b_delay > 0) begin
            b_delay--;
            if (b_delay == 0) b_valid = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: test %0s did not finish within %0d cycles", cur_name, cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        a_addr   = '0;
        b_addr   = '0;
        c_addr   = '0;
        width    = '0;
        cur_name = "none";
        cur_c    = '0;
        cur_exp  = '0;
        load_stimulus();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // back to back, each starts right after done_o rises
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        // let the checker close the last test
        repeat (2) @(negedge clk);
        $display("%0d of %0d tests done, %0d failed, %0d errors",
                 tests_done, n_tests, tests_failed, errors);
        if (errors == 0 && n_tests > 0 && tests_done == n_tests) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
